/* gcn_weight_stage.f */
+incdir+hw
hw/gcn_pkg.sv
hw/weight_source_mem.sv
hw/weight_loader.sv
hw/column_bank.sv
hw/feature_mac.sv
hw/gcn_weight_stage.sv
dv/gcn_weight_stage_tb.sv

/* dv/gcn_weight_stage_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "gcn_weight_settings.svh"

module gcn_weight_stage_tb
  import gcn_pkg::*;
();

  localparam int ROWS           = `GCN_W_ROWS;
  localparam int COLS           = `GCN_W_COLS;
  localparam int DW             = `GCN_DATA_W;
  localparam int ACC_W          = `GCN_ACC_W;
  localparam int SRC_AW         = `GCN_SRC_ADDR_W;
  localparam int NUM_TESTS      = 5;
  localparam int LOAD_TIMEOUT   = 400;
  localparam int RESULT_TIMEOUT = 50;

  // one row of the test table
  typedef struct packed {
    logic       check_reset;
    logic       new_matrix;
    logic       pause_load;
    logic       early_strobes;
    logic [3:0] num_vectors;
  } test_row_t;

  logic        clk;
  logic        rst_n;
  src_write_t  src_wr;
  logic        load_en;
  logic        reload;
  logic        feat_valid;
  logic [DW-1:0] feat_data;
  logic        weights_ready;
  logic        result_valid;
  mac_result_t result;

  test_row_t     test_table [NUM_TESTS];
  string         test_name [NUM_TESTS];
  logic [31:0]   lfsr;
  logic [DW-1:0] model [ROWS][COLS];
  mac_result_t   expected_q [$];
  string         cur_test;
  int            error_count;
  int            tests_passed;
  int            tests_failed;

  gcn_weight_stage gcn_weight_stage_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .src_wr        (src_wr),
    .load_en       (load_en),
    .reload        (reload),
    .feat_valid    (feat_valid),
    .feat_data     (feat_data),
    .weights_ready (weights_ready),
    .result_valid  (result_valid),
    .result        (result)
  );

  always #20 clk = ~clk;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic next_byte(output logic [DW-1:0] b);
    for (int i = 0; i < DW; i++) begin
      lfsr = lfsr_step(lfsr);
      b    = {b[DW-2:0], lfsr[0]};
    end
  endtask

  // outputs settle at the edge, inputs change 2 ns later
  task automatic step_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("** Error %s: %s expected %0d actual %0d", cur_test, what, exp, act);
      error_count++;
    end
  endtask

  task automatic write_matrix();
    logic [DW-1:0] b;
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        next_byte(b);
        model[r][c] = b;
        src_wr = '{we: 1'b1, addr: SRC_AW'(r * COLS + c), data: b};
        step_cycle();
      end
    end
    src_wr = '0;
  endtask

  task automatic pulse_reload();
    reload = 1'b1;
    step_cycle();
    reload = 1'b0;
    check_value("weights_ready after reload", 0, weights_ready);
  endtask

  // none of these may reach the MAC
  task automatic send_early_strobes();
    logic [DW-1:0] f;
    for (int r = 0; r < ROWS; r++) begin
      next_byte(f);
      feat_valid = 1'b1;
      feat_data  = f;
      step_cycle();
      check_value("result_valid during early strobes", 0, result_valid);
    end
    feat_valid = 1'b0;
    feat_data  = '0;
    step_cycle();
    check_value("result_valid after early strobes", 0, result_valid);
  endtask

  // pause drops load_en on every third cycle
  task automatic load_weights(input logic pause, input logic check_latency, output logic ok);
    int waited;
    waited  = 0;
    load_en = 1'b1;
    while (!weights_ready && waited < LOAD_TIMEOUT) begin
      step_cycle();
      waited++;
      load_en = pause ? (waited % 3 != 2) : 1'b1;
    end
    load_en = 1'b0;
    ok      = weights_ready;
    assert (weights_ready) else begin
      $display("%s: timed out waiting for weights_ready", cur_test);
      error_count++;
    end
    if (ok && check_latency) begin
      check_value("load latency in cycles", ROWS * COLS + 2, waited - 1);
    end
  endtask

  task automatic check_result_cycle();
    mac_result_t exp;
    if (result_valid) begin
      assert (expected_q.size() > 0) else begin
        $display("%s: result_valid pulsed with no vector outstanding", cur_test);
        error_count++;
      end
      if (expected_q.size() > 0) begin
        exp = expected_q.pop_front();
        for (int c = 0; c < COLS; c++) begin
          check_value($sformatf("result col %0d", c), exp[c], result[c]);
        end
      end
    end
  endtask

  // vectors follow each other with no gap
  task automatic stream_vectors(input int n);
    logic [DW-1:0] feat [ROWS];
    mac_result_t   exp;
    int            sum;
    for (int v = 0; v < n; v++) begin
      for (int r = 0; r < ROWS; r++) begin
        next_byte(feat[r]);
      end
      for (int c = 0; c < COLS; c++) begin
        sum = 0;
        for (int r = 0; r < ROWS; r++) begin
          sum += feat[r] * model[r][c];
        end
        exp[c] = ACC_W'(sum);
      end
      expected_q.push_back(exp);
      for (int r = 0; r < ROWS; r++) begin
        feat_valid = 1'b1;
        feat_data  = feat[r];
        step_cycle();
        check_result_cycle();
      end
    end
    feat_valid = 1'b0;
    feat_data  = '0;
  endtask

  task automatic wait_results();
    int waited;
    waited = 0;
    while (expected_q.size() > 0 && waited < RESULT_TIMEOUT) begin
      step_cycle();
      check_result_cycle();
      waited++;
    end
    assert (expected_q.size() == 0) else begin
      $display("%s: timed out waiting for result_valid, %0d results missing",
               cur_test, expected_q.size());
      error_count++;
      expected_q.delete();
    end
    // a stray pulse here has no vector behind it
    repeat (2) begin
      step_cycle();
      check_result_cycle();
    end
  endtask

  initial begin
    logic ok;
    int   errors_at_start;
    clk          = 1'b0;
    rst_n        = 1'b0;
    src_wr       = '0;
    load_en      = 1'b0;
    reload       = 1'b0;
    feat_valid   = 1'b0;
    feat_data    = '0;
    lfsr         = 32'hec917096;
    error_count  = 0;
    tests_passed = 0;
    tests_failed = 0;

    test_table[0] = '{1'b1, 1'b1, 1'b0, 1'b0, 4'd1};
    test_name[0]  = "reset_and_load";
    test_table[1] = '{1'b0, 1'b0, 1'b0, 1'b0, 4'd4};
    test_name[1]  = "back_to_back_vectors";
    test_table[2] = '{1'b0, 1'b1, 1'b1, 1'b0, 4'd3};
    test_name[2]  = "paused_load";
    test_table[3] = '{1'b0, 1'b1, 1'b0, 1'b1, 4'd1};
    test_name[3]  = "early_strobes";
    test_table[4] = '{1'b0, 1'b1, 1'b0, 1'b0, 4'd3};
    test_name[4]  = "reload_new_matrix";

    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;

    for (int t = 0; t < NUM_TESTS; t++) begin
      cur_test        = test_name[t];
      errors_at_start = error_count;
      ok              = 1'b1;
      if (test_table[t].check_reset) begin
        check_value("weights_ready after reset", 0, weights_ready);
        check_value("result_valid after reset", 0, result_valid);
      end
      if (test_table[t].new_matrix) begin
        write_matrix();
        pulse_reload();
      end
      if (test_table[t].early_strobes) begin
        send_early_strobes();
      end
      if (test_table[t].new_matrix) begin
        load_weights(test_table[t].pause_load, !test_table[t].pause_load, ok);
      end
      if (ok) begin
        stream_vectors(test_table[t].num_vectors);
        wait_results();
      end
      if (error_count == errors_at_start) begin
        tests_passed++;
        $display("%s: passed", cur_test);
      end else begin
        tests_failed++;
        $display("%s: failed with %0d errors", cur_test, error_count - errors_at_start);
      end
    end

    $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (tests_failed == 0 && error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hw/gcn_weight_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "gcn_weight_settings.svh"

module gcn_weight_stage
  import gcn_pkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire src_write_t             src_wr,
  input  wire logic                   load_en,
  input  wire logic                   reload,
  input  wire logic                   feat_valid,
  input  wire logic [`GCN_DATA_W-1:0] feat_data,
  output      logic                   weights_ready,
  output      logic                   result_valid,
  output      mac_result_t            result
);

  logic                                    src_rd_en;
  logic [`GCN_SRC_ADDR_W-1:0]              src_rd_addr;
  logic [`GCN_DATA_W-1:0]                  src_rd_data;
  bank_write_t                             bank_wr;
  logic [`GCN_W_COLS-1:0]                  bank_en;
  logic [`GCN_ROW_W-1:0]                   rd_row;
  logic [`GCN_W_COLS-1:0][`GCN_DATA_W-1:0] bank_data;

  weight_source_mem weight_source_mem_inst (
    .clk     (clk),
    .src_wr  (src_wr),
    .rd_en   (src_rd_en),
    .rd_addr (src_rd_addr),
    .rd_data (src_rd_data)
  );

  weight_loader weight_loader_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .load_en       (load_en),
    .reload        (reload),
    .src_rd_en     (src_rd_en),
    .src_rd_addr   (src_rd_addr),
    .src_rd_data   (src_rd_data),
    .bank_wr       (bank_wr),
    .bank_en       (bank_en),
    .weights_ready (weights_ready)
  );

  // one bank per matrix column, all read at the same row
  for (genvar c = 0; c < `GCN_W_COLS; c++) begin : gen_bank
    column_bank column_bank_inst (
      .clk     (clk),
      .wr_en   (bank_en[c]),
      .wr      (bank_wr),
      .rd_row  (rd_row),
      .rd_data (bank_data[c])
    );
  end

  feature_mac feature_mac_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .weights_ready (weights_ready),
    .feat_valid    (feat_valid),
    .feat_data     (feat_data),
    .rd_row        (rd_row),
    .bank_data     (bank_data),
    .result_valid  (result_valid),
    .result        (result)
  );

endmodule

`default_nettype wire

/* hw/feature_mac.sv */
`timescale 1ns/1ns
`default_nettype none

`include "gcn_weight_settings.svh"

module feature_mac
  import gcn_pkg::*;
(
  input  wire logic                                    clk,
  input  wire logic                                    rst_n,
  input  wire logic                                    weights_ready,
  input  wire logic                                    feat_valid,
  input  wire logic [`GCN_DATA_W-1:0]                  feat_data,
  output      logic [`GCN_ROW_W-1:0]                   rd_row,
  input  wire logic [`GCN_W_COLS-1:0][`GCN_DATA_W-1:0] bank_data,
  output      logic                                    result_valid,
  output      mac_result_t                             result
);

  localparam logic [`GCN_ROW_W-1:0] LAST_ELEM = `GCN_ROW_W'(`GCN_W_ROWS - 1);

  logic [`GCN_ROW_W-1:0] elem_cnt;
  mac_result_t           acc;
  mac_result_t           acc_next;
  logic                  accept;
  logic                  last_elem;

  // strobes before the matrix is loaded are dropped
  assign accept    = feat_valid && weights_ready;
  assign last_elem = (elem_cnt == LAST_ELEM);

  // element index selects the matrix row in every bank
  assign rd_row = elem_cnt;

  // one product per column, added in accumulator width
  always_comb begin
    for (int c = 0; c < `GCN_W_COLS; c++) begin
      acc_next[c] = acc[c] + feat_data * bank_data[c];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      elem_cnt     <= '0;
      acc          <= '0;
      result_valid <= 1'b0;
    end else begin
      result_valid <= accept && last_elem;
      if (accept) begin
        if (last_elem) begin
          // clear right away so the next vector can follow back to back
          elem_cnt <= '0;
          acc      <= '0;
        end else begin
          elem_cnt <= elem_cnt + 1'b1;
          acc      <= acc_next;
        end
      end
    end
  end

  // final sums include the last element's products
  always_ff @(posedge clk) begin
    if (accept && last_elem) begin
      result <= acc_next;
    end
  end

endmodule

`default_nettype wire

/* hw/column_bank.sv */
`timescale 1ns/1ns
`default_nettype none

`include "gcn_weight_settings.svh"

module column_bank
  import gcn_pkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   wr_en,
  input  wire bank_write_t            wr,
  input  wire logic [`GCN_ROW_W-1:0]  rd_row,
  output      logic [`GCN_DATA_W-1:0] rd_data
);

  // one matrix column, indexed by row
  logic [`GCN_DATA_W-1:0] mem [0:`GCN_W_ROWS-1];

  // loader port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr.row] <= wr.data;
    end
  end

  // zero-latency read for the MAC
  assign rd_data = mem[rd_row];

endmodule

`default_nettype wire

/* hw/weight_loader.sv */
`timescale 1ns/1ns
`default_nettype none

`include "gcn_weight_settings.svh"

module weight_loader
  import gcn_pkg::*;
(
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  wire logic                       load_en,
  input  wire logic                       reload,
  output      logic                       src_rd_en,
  output      logic [`GCN_SRC_ADDR_W-1:0] src_rd_addr,
  input  wire logic [`GCN_DATA_W-1:0]     src_rd_data,
  output      bank_write_t                bank_wr,
  output      logic [`GCN_W_COLS-1:0]     bank_en,
  output      logic                       weights_ready
);

  localparam logic [`GCN_SRC_ADDR_W-1:0] LAST_ADDR =
    `GCN_SRC_ADDR_W'(`GCN_W_ROWS * `GCN_W_COLS - 1);
  localparam logic [`GCN_ROW_W-1:0] LAST_ROW = `GCN_ROW_W'(`GCN_W_ROWS - 1);
  localparam logic [`GCN_COL_W-1:0] LAST_COL = `GCN_COL_W'(`GCN_W_COLS - 1);

  load_state_t                state;
  logic [`GCN_SRC_ADDR_W-1:0] fetch_addr;
  logic                       issued_all;
  logic                       rd_vld;
  logic [`GCN_ROW_W-1:0]      row_idx;
  logic [`GCN_COL_W-1:0]      col_idx;
  logic                       last_write;

  // one read per cycle while fetching and enabled, until the last address is out
  assign src_rd_en   = (state == LOAD_FETCH) && load_en && !issued_all;
  assign src_rd_addr = fetch_addr;

  // returned byte goes to bank col_idx at row row_idx
  assign bank_wr    = '{row: row_idx, data: src_rd_data};
  assign last_write = rd_vld && (row_idx == LAST_ROW) && (col_idx == LAST_COL);

  always_comb begin
    bank_en = '0;
    if (rd_vld) begin
      bank_en[col_idx] = 1'b1;
    end
  end

  // FSM and ready flag
  always_ff @(posedge clk) begin
    if (!rst_n || reload) begin
      state         <= LOAD_IDLE;
      weights_ready <= 1'b0;
    end else begin
      case (state)
        LOAD_IDLE: begin
          if (load_en) begin
            state <= LOAD_FETCH;
          end
        end
        LOAD_FETCH: begin
          if (last_write) begin
            state <= LOAD_DONE;
          end
        end
        default: begin
          state <= state;
        end
      endcase
      // rises one edge after LOAD_DONE is entered
      weights_ready <= (state == LOAD_DONE);
    end
  end

  // read side: fetch address and in-flight flag
  always_ff @(posedge clk) begin
    if (!rst_n || reload) begin
      fetch_addr <= '0;
      issued_all <= 1'b0;
      rd_vld     <= 1'b0;
    end else begin
      // delayed copy of the read enable, a read issued as load_en drops still lands
      rd_vld <= src_rd_en;
      if (src_rd_en) begin
        if (fetch_addr == LAST_ADDR) begin
          issued_all <= 1'b1;
        end else begin
          fetch_addr <= fetch_addr + 1'b1;
        end
      end
    end
  end

  // write side: column first, then row
  always_ff @(posedge clk) begin
    if (!rst_n || reload) begin
      row_idx <= '0;
      col_idx <= '0;
    end else if (rd_vld) begin
      if (col_idx == LAST_COL) begin
        col_idx <= '0;
        row_idx <= (row_idx == LAST_ROW) ? '0 : row_idx + 1'b1;
      end else begin
        col_idx <= col_idx + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/weight_source_mem.sv */
`timescale 1ns/1ns
`default_nettype none

`include "gcn_weight_settings.svh"

module weight_source_mem
  import gcn_pkg::*;
(
  input  wire logic                       clk,
  input  wire src_write_t                 src_wr,
  input  wire logic                       rd_en,
  input  wire logic [`GCN_SRC_ADDR_W-1:0] rd_addr,
  output      logic [`GCN_DATA_W-1:0]     rd_data
);

  localparam int DEPTH = `GCN_W_ROWS * `GCN_W_COLS;

  // whole matrix, row-major, element (r, c) at r * W_COLS + c
  logic [`GCN_DATA_W-1:0] mem [0:DEPTH-1];

  // host port
  always_ff @(posedge clk) begin
    if (src_wr.we) begin
      mem[src_wr.addr] <= src_wr.data;
    end
  end

  // registered read port, data one cycle after the enable
  // a read of an address written on the same edge sees the old byte
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

/* hw/gcn_pkg.sv */
`default_nettype none

`include "gcn_weight_settings.svh"

package gcn_pkg;

  // host write into the row-major source memory
  typedef struct packed {
    logic                       we;
    logic [`GCN_SRC_ADDR_W-1:0] addr;
    logic [`GCN_DATA_W-1:0]     data;
  } src_write_t;

  // loader write, shared by all banks
  // the bank enable travels as a separate one-hot vector
  typedef struct packed {
    logic [`GCN_ROW_W-1:0]  row;
    logic [`GCN_DATA_W-1:0] data;
  } bank_write_t;

  // one finished result row, one accumulator per column
  typedef logic [`GCN_W_COLS-1:0][`GCN_ACC_W-1:0] mac_result_t;

  // loader FSM
  typedef enum logic [1:0] {
    LOAD_IDLE  = 2'd0,
    LOAD_FETCH = 2'd1,
    LOAD_DONE  = 2'd2
  } load_state_t;

endpackage

`default_nettype wire

/* hw/gcn_weight_settings.svh */
`ifndef GCN_WEIGHT_SETTINGS_SVH
`define GCN_WEIGHT_SETTINGS_SVH

// width of one weight or feature element
`define GCN_DATA_W 8

// matrix shape, rows double as the feature vector length
`define GCN_W_ROWS 8
`define GCN_W_COLS 4

// index widths for row, column and flat source address
`define GCN_ROW_W 3
`define GCN_COL_W 2
`define GCN_SRC_ADDR_W 5

// 8 products of two bytes need 19 bits, one spare
`define GCN_ACC_W 20

`endif
